//--- io_axil_regs.sv
//*********************************************************************
// AXI4-Lite register block: millisecond counter, LEDs, UART status,
// configuration word, and pushes of transmit bytes into the FIFO
//*********************************************************************

`timescale 1ns/1ps
`default_nettype none

`include "io_params.svh"

module io_axil_regs
    import io_pkg::*;
#(
    parameter int TICKS_PER_MS = `IO_TICKS_PER_MS
) (
    input  wire logic         clk_cpu,
    input  wire logic         rst_n,
    input  wire io_axil_req_t axil_req_i,
    output      io_axil_rsp_t axil_rsp_o,
    output      io_byte_t     led_o,
    output      logic         push_o,
    output      io_byte_t     push_data_o,
    input  wire logic         fifo_full_i,
    input  wire logic         fifo_empty_i,
    input  wire logic         tx_idle_i
);

    localparam int PRE_W = $clog2(TICKS_PER_MS + 1);

    logic             aw_ready_q;  // Shared by awready and wready
    logic             b_valid_q;
    logic             ar_ready_q;
    logic             r_valid_q;
    io_word_t         r_data_q;
    io_reg_idx_t      wr_idx;
    io_reg_idx_t      rd_idx;
    logic             tx_blocked;
    logic             wr_take;
    logic             ar_take;
    logic [PRE_W-1:0] pre_cnt;
    logic             ms_tick;
    io_word_t         ms_cnt;
    io_word_t         status;
    io_word_t         rd_word;

    assign wr_idx = axil_req_i.awaddr[6:2];
    assign rd_idx = axil_req_i.araddr[6:2];

    // Write channel. The ready pulse comes one cycle after the
    // request is seen; bvalid closes the window for a second pulse
    assign tx_blocked = (wr_idx == `IO_REG_TX_DATA) && fifo_full_i;
    assign wr_take    = axil_req_i.awvalid && axil_req_i.wvalid && !aw_ready_q
                        && !b_valid_q && !tx_blocked;

    always_ff @(posedge clk_cpu) begin
        if (rst_n) begin
            aw_ready_q <= 1'b0;
            b_valid_q  <= 1'b0;
            led_o      <= '0;
        end else begin
            aw_ready_q <= wr_take;
            if (aw_ready_q) begin
                b_valid_q <= 1'b1;
            end else if (axil_req_i.bready) begin
                b_valid_q <= 1'b0;  // Response taken
            end
            if (aw_ready_q && wr_idx == `IO_REG_LED && axil_req_i.wstrb[0]) begin
                led_o <= axil_req_i.wdata[7:0];
            end
        end
    end

    // One push per accepted TX_DATA write with the low lane enabled
    assign push_o      = aw_ready_q && (wr_idx == `IO_REG_TX_DATA) && axil_req_i.wstrb[0];
    assign push_data_o = axil_req_i.wdata[7:0];

    // Read channel, independent of the write side
    assign ar_take = axil_req_i.arvalid && !ar_ready_q && !r_valid_q;

    always_ff @(posedge clk_cpu) begin
        if (rst_n) begin
            ar_ready_q <= 1'b0;
            r_valid_q  <= 1'b0;
        end else begin
            ar_ready_q <= ar_take;
            if (ar_ready_q) begin
                r_valid_q <= 1'b1;
            end else if (axil_req_i.rready) begin
                r_valid_q <= 1'b0;
            end
        end
    end

    // Data is captured in the arready cycle and held until taken
    always_ff @(posedge clk_cpu) begin
        if (ar_ready_q) begin
            r_data_q <= rd_word;
        end
    end

    // Millisecond tick prescaler
    assign ms_tick = (pre_cnt == PRE_W'(TICKS_PER_MS - 1));

    always_ff @(posedge clk_cpu) begin
        if (rst_n) begin
            pre_cnt <= '0;
            ms_cnt  <= '0;
        end else if (ms_tick) begin
            pre_cnt <= '0;
            ms_cnt  <= ms_cnt + 32'd1;
        end else begin
            pre_cnt <= pre_cnt + 1'b1;
        end
    end

    // Bit 1 room in FIFO, bit 2 transmit path drained
    assign status = {29'd0, fifo_empty_i && tx_idle_i, !fifo_full_i, 1'b0};

    // LED, TX data and unmapped indices read as zero
    always_comb begin
        case (rd_idx)
            `IO_REG_MS:      rd_word = ms_cnt;
            `IO_REG_TX_STAT: rd_word = status;
            `IO_REG_HW_CFG:  rd_word = `IO_HW_CONFIG;
            default:         rd_word = '0;
        endcase
    end

    assign axil_rsp_o.awready = aw_ready_q;
    assign axil_rsp_o.wready  = aw_ready_q;
    assign axil_rsp_o.bvalid  = b_valid_q;
    assign axil_rsp_o.bresp   = IO_RESP_OKAY;  // No error path
    assign axil_rsp_o.arready = ar_ready_q;
    assign axil_rsp_o.rvalid  = r_valid_q;
    assign axil_rsp_o.rdata   = r_data_q;
    assign axil_rsp_o.rresp   = IO_RESP_OKAY;

endmodule

`default_nettype wire

//--- io_params.svh
//*********************************************************************
// Default parameters, register word indices and configuration word
// of the I/O block. Include it wherever these macros are needed
//*********************************************************************

`ifndef IO_PARAMS_SVH
`define IO_PARAMS_SVH

// Defaults for a 25 MHz clk_cpu
`define IO_TICKS_PER_MS   25000   // Cycles per millisecond tick
`define IO_CLKS_PER_BIT   217     // About 115200 baud
`define IO_TX_FIFO_DEPTH  8       // Power of two only

// Word indices inside the I/O window
`define IO_REG_MS         5'd0    // Millisecond counter, read-only
`define IO_REG_LED        5'd1    // LEDs, write-only
`define IO_REG_TX_DATA    5'd2    // UART transmit byte
`define IO_REG_TX_STAT    5'd3    // UART status
`define IO_REG_HW_CFG     5'd14   // Hardware configuration

// Bit 31 flags simulation; peripheral-present bits 4..0 stay clear
`define IO_HW_CONFIG      32'h8000_0000

`endif

//--- io_pkg.sv
//*********************************************************************
// Shared types of the I/O block: data widths, AXI4-Lite channel
// structs and the serializer states. Imported by every module
//*********************************************************************

`default_nettype none

package io_pkg;

    typedef logic [31:0] io_word_t;    // Bus data word
    typedef logic [7:0]  io_byte_t;    // UART byte, LED value
    typedef logic [7:0]  io_addr_t;    // Byte address in the I/O window
    typedef logic [4:0]  io_reg_idx_t; // Word index, address bits 6:2

    // Master to slave
    typedef struct packed {
        logic       awvalid;
        io_addr_t   awaddr;
        logic       wvalid;
        io_word_t   wdata;
        logic [3:0] wstrb;
        logic       bready;
        logic       arvalid;
        io_addr_t   araddr;
        logic       rready;
    } io_axil_req_t;

    // Slave to master
    typedef struct packed {
        logic       awready;
        logic       wready;
        logic       bvalid;
        logic [1:0] bresp;
        logic       arready;
        logic       rvalid;
        io_word_t   rdata;
        logic [1:0] rresp;
    } io_axil_rsp_t;

    localparam logic [1:0] IO_RESP_OKAY = 2'b00;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } io_tx_state_e;

endpackage

`default_nettype wire

//--- io_soc_sva.sv
//*********************************************************************
// Handshake and transmit line assertions, bound into the I/O top
//*********************************************************************

`timescale 1ns/1ps
`default_nettype none

module io_soc_sva
    import io_pkg::*;
(
    input wire logic         clk_cpu,
    input wire logic         rst_n,
    input wire io_axil_req_t axil_req_i,
    input wire io_axil_rsp_t axil_rsp_o,
    input wire logic         tx_o
);

    int fail_cnt = 0;  // Read by the testbench at the end

    bvalid_hold: assert property (@(posedge clk_cpu) disable iff (rst_n)
        axil_rsp_o.bvalid && !axil_req_i.bready |=> axil_rsp_o.bvalid)
        else begin
            $error("bvalid dropped before bready");
            fail_cnt++;
        end

    rvalid_hold: assert property (@(posedge clk_cpu) disable iff (rst_n)
        axil_rsp_o.rvalid && !axil_req_i.rready |=> axil_rsp_o.rvalid)
        else begin
            $error("rvalid dropped before rready");
            fail_cnt++;
        end

    rdata_stable: assert property (@(posedge clk_cpu) disable iff (rst_n)
        axil_rsp_o.rvalid && !axil_req_i.rready |=> $stable(axil_rsp_o.rdata))
        else begin
            $error("rdata changed while rvalid waited");
            fail_cnt++;
        end

    // Reset is active high
    tx_high_after_reset: assert property (@(posedge clk_cpu) rst_n |=> tx_o)
        else begin
            $error("tx_o low right after reset");
            fail_cnt++;
        end

    awready_pulse: assert property (@(posedge clk_cpu) disable iff (rst_n)
        axil_rsp_o.awready |=> !axil_rsp_o.awready)
        else begin
            $error("awready longer than one cycle");
            fail_cnt++;
        end

    arready_pulse: assert property (@(posedge clk_cpu) disable iff (rst_n)
        axil_rsp_o.arready |=> !axil_rsp_o.arready)
        else begin
            $error("arready longer than one cycle");
            fail_cnt++;
        end

endmodule

bind io_soc_top io_soc_sva io_soc_sva_i (
    .clk_cpu   (clk_cpu),
    .rst_n     (rst_n),
    .axil_req_i(axil_req_i),
    .axil_rsp_o(axil_rsp_o),
    .tx_o      (tx_o)
);

`default_nettype wire

//--- io_soc_top.sv
//*********************************************************************
// Top of the I/O block: AXI4-Lite register block feeding the UART
// serializer through the transmit FIFO
//*********************************************************************

`timescale 1ns/1ps
`default_nettype none

`include "io_params.svh"

module io_soc_top
    import io_pkg::*;
#(
    parameter int TICKS_PER_MS = `IO_TICKS_PER_MS,
    parameter int CLKS_PER_BIT = `IO_CLKS_PER_BIT,
    parameter int FIFO_DEPTH   = `IO_TX_FIFO_DEPTH
) (
    input  wire logic         clk_cpu,
    input  wire logic         rst_n,
    input  wire io_axil_req_t axil_req_i,
    output      io_axil_rsp_t axil_rsp_o,
    output      io_byte_t     led_o,
    output      logic         tx_o
);

    logic     push;
    io_byte_t push_data;
    logic     pop;
    io_byte_t fifo_head;
    logic     fifo_empty;
    logic     fifo_full;
    logic     tx_idle;

    io_axil_regs #(
        .TICKS_PER_MS(TICKS_PER_MS)
    ) io_axil_regs_i (
        .clk_cpu     (clk_cpu),
        .rst_n       (rst_n),
        .axil_req_i  (axil_req_i),
        .axil_rsp_o  (axil_rsp_o),
        .led_o       (led_o),
        .push_o      (push),
        .push_data_o (push_data),
        .fifo_full_i (fifo_full),
        .fifo_empty_i(fifo_empty),
        .tx_idle_i   (tx_idle)
    );

    io_tx_fifo #(
        .DEPTH(FIFO_DEPTH)
    ) io_tx_fifo_i (
        .clk_cpu    (clk_cpu),
        .rst_n      (rst_n),
        .push_i     (push),
        .push_data_i(push_data),
        .pop_i      (pop),
        .head_o     (fifo_head),
        .empty_o    (fifo_empty),
        .full_o     (fifo_full)
    );

    io_uart_tx #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) io_uart_tx_i (
        .clk_cpu     (clk_cpu),
        .rst_n       (rst_n),
        .fifo_empty_i(fifo_empty),
        .fifo_head_i (fifo_head),
        .pop_o       (pop),
        .tx_idle_o   (tx_idle),
        .tx_o        (tx_o)
    );

endmodule

`default_nettype wire

//--- io_tx_fifo.sv
//*********************************************************************
// First-word-fall-through byte FIFO between the register block and
// the UART serializer. DEPTH must be a power of two
//*********************************************************************

`timescale 1ns/1ps
`default_nettype none

`include "io_params.svh"

module io_tx_fifo
    import io_pkg::*;
#(
    parameter int DEPTH = `IO_TX_FIFO_DEPTH
) (
    input  wire logic     clk_cpu,
    input  wire logic     rst_n,
    input  wire logic     push_i,
    input  wire io_byte_t push_data_i,
    input  wire logic     pop_i,
    output      io_byte_t head_o,
    output      logic     empty_o,
    output      logic     full_o
);

    localparam int AW    = $clog2(DEPTH);
    localparam int CNT_W = AW + 1;

    io_byte_t         mem [DEPTH];
    logic [AW-1:0]    wr_ptr;
    logic [AW-1:0]    rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign empty_o = (count == '0);
    assign full_o  = (count == CNT_W'(DEPTH));
    assign head_o  = mem[rd_ptr];  // Valid while not empty

    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;

    always_ff @(posedge clk_cpu) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data_i;
        end
    end

    // Pointers wrap on their own since DEPTH is a power of two
    always_ff @(posedge clk_cpu) begin
        if (rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- io_uart_tx.sv
//*********************************************************************
// UART serializer, 8N1, least significant bit first. Pops one byte
// from the FIFO per frame and sends frames back to back
//*********************************************************************

`timescale 1ns/1ps
`default_nettype none

`include "io_params.svh"

module io_uart_tx
    import io_pkg::*;
#(
    parameter int CLKS_PER_BIT = `IO_CLKS_PER_BIT
) (
    input  wire logic     clk_cpu,
    input  wire logic     rst_n,
    input  wire logic     fifo_empty_i,
    input  wire io_byte_t fifo_head_i,
    output      logic     pop_o,
    output      logic     tx_idle_o,
    output      logic     tx_o
);

    localparam int CW = $clog2(CLKS_PER_BIT);

    io_tx_state_e  state;
    logic [CW-1:0] clk_cnt;
    logic [2:0]    bit_idx;
    io_byte_t      shreg;
    logic          bit_end;
    logic          stop_end;

    assign bit_end   = (clk_cnt == CW'(CLKS_PER_BIT - 1));
    // The idle cycle after STOP is the last cycle of the stop bit
    assign stop_end  = (clk_cnt == CW'(CLKS_PER_BIT - 2));
    assign tx_idle_o = (state == TX_IDLE);
    assign pop_o     = tx_idle_o && !fifo_empty_i;

    always_ff @(posedge clk_cpu) begin
        if (rst_n) begin
            state   <= TX_IDLE;
            clk_cnt <= '0;
            bit_idx <= '0;
            tx_o    <= 1'b1;  // Line idles high
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
            case (state)
                TX_IDLE: begin
                    clk_cnt <= '0;
                    if (pop_o) begin
                        state <= TX_START;
                        tx_o  <= 1'b0;  // Start bit
                    end
                end
                TX_START: begin
                    if (bit_end) begin
                        state   <= TX_DATA;
                        clk_cnt <= '0;
                        bit_idx <= '0;
                        tx_o    <= shreg[0];
                    end
                end
                TX_DATA: begin
                    if (bit_end) begin
                        clk_cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= TX_STOP;
                            tx_o  <= 1'b1;
                        end else begin
                            tx_o <= shreg[bit_idx + 1'b1];
                        end
                    end
                end
                TX_STOP: begin
                    if (stop_end) begin
                        state <= TX_IDLE;
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    // Byte latched at pop time
    always_ff @(posedge clk_cpu) begin
        if (pop_o) begin
            shreg <= fifo_head_i;
        end
    end

endmodule

`default_nettype wire

//--- tb_io_checker.sv
//*********************************************************************
// Checker for the I/O block. Models the registers and the millisecond
// count, decodes tx_o and compares every response it sees
//*********************************************************************

`timescale 1ns/1ps
`default_nettype none

`include "io_params.svh"

module tb_io_checker
    import io_pkg::*;
#(
    parameter int TICKS_PER_MS = 16,
    parameter int CLKS_PER_BIT = 8
) (
    input  wire logic         clk_cpu,
    input  wire logic         rst_n,
    input  wire io_axil_req_t axil_req_i,
    input  wire io_axil_rsp_t axil_rsp_i,
    input  wire io_byte_t     led_i,
    input  wire logic         tx_i,
    input  wire io_word_t     exp_rdata_i,
    input  wire logic         exp_model_i,
    output int                pending_o,
    output int                err_rd_o,
    output int                err_led_o,
    output int                err_tx_o,
    output int                err_bus_o
);

    io_byte_t    tx_q [$];   // Accepted bytes not yet seen on tx_o
    int unsigned cyc;        // Cycles since reset release
    io_word_t    rd_exp;
    logic        rd_is_ms;
    io_word_t    last_ms;
    io_byte_t    led_exp;
    logic        after_rst;
    logic        rx_busy;
    logic        tx_prev;
    int          rx_cnt;
    int          rx_bit;      // 0 start, 1..8 data, 9 stop
    io_byte_t    rx_byte;
    io_byte_t    tx_exp;
    io_reg_idx_t wr_idx;
    logic        aw_hs;
    int          n_rd  = 0;
    int          n_led = 0;
    int          n_tx  = 0;
    int          n_bus = 0;

    assign wr_idx    = axil_req_i.awaddr[6:2];
    assign aw_hs     = axil_req_i.awvalid && axil_rsp_i.awready;
    assign err_rd_o  = n_rd;
    assign err_led_o = n_led;
    assign err_tx_o  = n_tx;
    assign err_bus_o = n_bus;

    // LED model, read data, response codes and millisecond prediction
    always @(posedge clk_cpu) begin
        if (rst_n) begin
            cyc     <= 0;
            led_exp <= '0;
            last_ms <= '0;
        end else begin
            if (led_i !== led_exp) begin
                $display("[FAIL] %0t ns: led_o expected %h, got %h", $time, led_exp, led_i);
                n_led++;
            end
            if (axil_rsp_i.wready !== axil_rsp_i.awready) begin  // Raised together
                $display("[FAIL] %0t ns: wready expected %b, got %b",
                         $time, axil_rsp_i.awready, axil_rsp_i.wready);
                n_bus++;
            end
            if (axil_rsp_i.bvalid && axil_req_i.bready && axil_rsp_i.bresp !== 2'b00) begin
                $display("[FAIL] %0t ns: bresp expected 0, got %0d", $time, axil_rsp_i.bresp);
                n_bus++;
            end
            if (aw_hs && wr_idx == `IO_REG_LED && axil_req_i.wstrb[0]) begin
                led_exp <= axil_req_i.wdata[7:0];
            end
            if (axil_req_i.arvalid && axil_rsp_i.arready) begin
                rd_is_ms <= exp_model_i;
                rd_exp   <= exp_model_i ? io_word_t'(cyc / TICKS_PER_MS) : exp_rdata_i;
            end
            if (axil_rsp_i.rvalid && axil_req_i.rready) begin
                if (axil_rsp_i.rdata !== rd_exp) begin
                    $display("[FAIL] %0t ns: rdata expected %h, got %h",
                             $time, rd_exp, axil_rsp_i.rdata);
                    n_rd++;
                end
                if (axil_rsp_i.rresp !== 2'b00) begin
                    $display("[FAIL] %0t ns: rresp expected 0, got %0d",
                             $time, axil_rsp_i.rresp);
                    n_bus++;
                end
                if (rd_is_ms) begin
                    if (axil_rsp_i.rdata < last_ms) begin
                        $display("Millisecond counter went backwards at %0t ns", $time);
                        n_rd++;
                    end
                    last_ms <= axil_rsp_i.rdata;
                end
            end
            cyc <= cyc + 1;
        end
    end

    // Byte queue and mid-bit sampling of tx_o
    always @(posedge clk_cpu) begin
        if (rst_n) begin
            tx_q.delete();
            rx_busy   = 1'b0;
            tx_prev   = 1'b1;
            rx_cnt    = 0;
            rx_bit    = 0;
            after_rst = 1'b1;
        end else begin
            if (after_rst && tx_i !== 1'b1) begin
                $display("[FAIL] %0t ns: tx_o expected 1, got %b", $time, tx_i);
                n_tx++;
            end
            after_rst = 1'b0;
            if (aw_hs && wr_idx == `IO_REG_TX_DATA && axil_req_i.wstrb[0]) begin
                tx_q.push_back(axil_req_i.wdata[7:0]);
            end
            if (!rx_busy) begin
                if (tx_prev && !tx_i) begin  // Start bit edge
                    rx_busy = 1'b1;
                    rx_cnt  = 0;
                    rx_bit  = 0;
                end
            end else begin
                rx_cnt++;
            end
            if (rx_busy && rx_cnt == rx_bit * CLKS_PER_BIT + CLKS_PER_BIT / 2) begin
                if (rx_bit == 0) begin
                    if (tx_i !== 1'b0) begin
                        $display("[FAIL] %0t ns: tx_o start bit expected 0, got %b", $time, tx_i);
                        n_tx++;
                    end
                end else if (rx_bit <= 8) begin
                    rx_byte[rx_bit-1] = tx_i;
                end else begin
                    if (tx_i !== 1'b1) begin
                        $display("[FAIL] %0t ns: tx_o stop bit expected 1, got %b", $time, tx_i);
                        n_tx++;
                    end
                    if (tx_q.size() == 0) begin
                        $display("Byte %h appeared on tx_o with no write behind it", rx_byte);
                        n_tx++;
                    end else begin
                        tx_exp = tx_q.pop_front();
                        if (rx_byte !== tx_exp) begin
                            $display("[FAIL] %0t ns: tx_o byte expected %h, got %h",
                                     $time, tx_exp, rx_byte);
                            n_tx++;
                        end
                    end
                    rx_busy = 1'b0;
                end
                rx_bit++;
            end
            tx_prev = tx_i;
        end
        pending_o <= tx_q.size();
    end

endmodule

`default_nettype wire

//--- tb_io_soc.sv
//*********************************************************************
// Testbench top for the I/O block. Runs a table of AXI4-Lite reads and
// writes with random idle and response stalls, then prints a verdict
//*********************************************************************

`timescale 1ns/1ps
`default_nettype none

`include "io_params.svh"

module tb_io_soc
    import io_pkg::*;
();

    localparam int TICKS_PER_MS = 16;
    localparam int CLKS_PER_BIT = 8;
    localparam int FIFO_DEPTH   = 4;
    localparam int DRAIN_CYCLES = FIFO_DEPTH * 10 * CLKS_PER_BIT;
    localparam int STALL_MAX    = 3 * 7 + 8;  // Idle, two stalls, handshakes

    localparam logic [1:0] OP_RD    = 2'd0;
    localparam logic [1:0] OP_WR    = 2'd1;
    localparam logic [1:0] OP_DRAIN = 2'd2;  // Wait until tx_o goes quiet

    typedef struct packed {
        logic [1:0]  op;
        io_reg_idx_t idx;
        io_word_t    data;
        logic [3:0]  strb;
        io_word_t    exp;
        logic        model;  // Expected value comes from the checker
    } step_t;

    logic         clk_cpu = 1'b0;
    logic         rst_n;
    io_axil_req_t axil_req;
    io_axil_rsp_t axil_rsp;
    io_byte_t     led;
    logic         tx;
    io_word_t     exp_rdata;
    logic         exp_model;
    int           pending;
    int           err_rd;
    int           err_led;
    int           err_tx;
    int           err_bus;
    int           err_other = 0;
    int           wd_cycles = 0;
    logic [31:0]  lfsr      = 32'ha2c1aac9;
    step_t        steps [$];

    always #50 clk_cpu = ~clk_cpu;  // 100 ns period

    io_soc_top #(
        .TICKS_PER_MS(TICKS_PER_MS),
        .CLKS_PER_BIT(CLKS_PER_BIT),
        .FIFO_DEPTH  (FIFO_DEPTH)
    ) io_soc_top_i (
        .clk_cpu   (clk_cpu),
        .rst_n     (rst_n),
        .axil_req_i(axil_req),
        .axil_rsp_o(axil_rsp),
        .led_o     (led),
        .tx_o      (tx)
    );

    tb_io_checker #(
        .TICKS_PER_MS(TICKS_PER_MS),
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) checker_i (
        .clk_cpu    (clk_cpu),
        .rst_n      (rst_n),
        .axil_req_i (axil_req),
        .axil_rsp_i (axil_rsp),
        .led_i      (led),
        .tx_i       (tx),
        .exp_rdata_i(exp_rdata),
        .exp_model_i(exp_model),
        .pending_o  (pending),
        .err_rd_o   (err_rd),
        .err_led_o  (err_led),
        .err_tx_o   (err_tx),
        .err_bus_o  (err_bus)
    );

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic get_rand(input int nbits, output int val);
        val = 0;
        for (int b = 0; b < nbits; b++) begin
            lfsr = lfsr_step(lfsr);
            val  = (val << 1) | lfsr[0];
        end
    endtask

    task automatic add_step(input logic [1:0] op, input io_reg_idx_t idx, input io_word_t data,
                            input logic [3:0] strb, input io_word_t exp, input logic model);
        step_t s;
        s = '{op, idx, data, strb, exp, model};
        steps.push_back(s);
    endtask

    task automatic write_reg(input io_reg_idx_t idx, input io_word_t data,
                             input logic [3:0] strb);
        int stall;
        get_rand(3, stall);
        axil_req.awvalid <= 1'b1;
        axil_req.awaddr  <= {1'b0, idx, 2'b00};
        axil_req.wvalid  <= 1'b1;
        axil_req.wdata   <= data;
        axil_req.wstrb   <= strb;
        do begin
            @(posedge clk_cpu);
        end while (!axil_rsp.awready);
        axil_req.awvalid <= 1'b0;
        axil_req.wvalid  <= 1'b0;
        repeat (stall) @(posedge clk_cpu);  // Hold off bready
        axil_req.bready <= 1'b1;
        do begin
            @(posedge clk_cpu);
        end while (!axil_rsp.bvalid);
        axil_req.bready <= 1'b0;
    endtask

    task automatic read_reg(input io_reg_idx_t idx, input io_word_t exp, input logic model);
        int stall;
        get_rand(3, stall);
        exp_rdata        <= exp;
        exp_model        <= model;
        axil_req.arvalid <= 1'b1;
        axil_req.araddr  <= {1'b0, idx, 2'b00};
        do begin
            @(posedge clk_cpu);
        end while (!axil_rsp.arready);
        axil_req.arvalid <= 1'b0;
        repeat (stall) @(posedge clk_cpu);  // Hold off rready
        axil_req.rready <= 1'b1;
        do begin
            @(posedge clk_cpu);
        end while (!axil_rsp.rvalid);
        axil_req.rready <= 1'b0;
    endtask

    // All accepted bytes decoded, then the rest of the stop bit
    task automatic wait_drain();
        while (pending != 0) begin
            @(posedge clk_cpu);
        end
        repeat (CLKS_PER_BIT) @(posedge clk_cpu);
    endtask

    task automatic build_table();
        add_step(OP_RD, `IO_REG_LED, '0, '0, 32'h0, 1'b0);
        add_step(OP_RD, `IO_REG_HW_CFG, '0, '0, `IO_HW_CONFIG, 1'b0);
        add_step(OP_RD, 5'd9, '0, '0, 32'h0, 1'b0);  // Unmapped
        add_step(OP_RD, `IO_REG_MS, '0, '0, '0, 1'b1);
        add_step(OP_WR, `IO_REG_LED, 32'h0000_005A, 4'hF, '0, 1'b0);
        add_step(OP_WR, `IO_REG_LED, 32'h0000_00C3, 4'hE, '0, 1'b0);  // Lane 0 off
        add_step(OP_RD, `IO_REG_LED, '0, '0, 32'h0, 1'b0);
        add_step(OP_WR, `IO_REG_TX_DATA, 32'h0000_0055, 4'hF, '0, 1'b0);
        add_step(OP_WR, `IO_REG_TX_DATA, 32'h0000_00A3, 4'h1, '0, 1'b0);
        add_step(OP_RD, `IO_REG_TX_STAT, '0, '0, 32'h2, 1'b0);  // One byte queued
        add_step(OP_RD, `IO_REG_MS, '0, '0, '0, 1'b1);
        add_step(OP_DRAIN, '0, '0, '0, '0, 1'b0);
        add_step(OP_RD, `IO_REG_TX_STAT, '0, '0, 32'h6, 1'b0);
        add_step(OP_WR, `IO_REG_TX_DATA, 32'h1234_5678, 4'h2, '0, 1'b0);  // No push
        add_step(OP_WR, `IO_REG_LED, 32'h0000_00FF, 4'h1, '0, 1'b0);
        add_step(OP_WR, `IO_REG_TX_DATA, 32'h0000_0001, 4'hF, '0, 1'b0);
        add_step(OP_WR, `IO_REG_TX_DATA, 32'h0000_0080, 4'hF, '0, 1'b0);
        add_step(OP_WR, `IO_REG_TX_DATA, 32'h0000_00FF, 4'hF, '0, 1'b0);
        add_step(OP_WR, `IO_REG_TX_DATA, 32'h0000_0000, 4'hF, '0, 1'b0);
        add_step(OP_WR, `IO_REG_TX_DATA, 32'h0000_003C, 4'hF, '0, 1'b0);
        add_step(OP_WR, `IO_REG_TX_DATA, 32'h0000_00E7, 4'hF, '0, 1'b0);
        add_step(OP_RD, `IO_REG_TX_STAT, '0, '0, 32'h0, 1'b0);  // FIFO full
        add_step(OP_RD, `IO_REG_MS, '0, '0, '0, 1'b1);
        add_step(OP_DRAIN, '0, '0, '0, '0, 1'b0);
        add_step(OP_RD, `IO_REG_TX_STAT, '0, '0, 32'h6, 1'b0);
        add_step(OP_RD, `IO_REG_MS, '0, '0, '0, 1'b1);
        add_step(OP_WR, 5'd17, 32'hDEAD_BEEF, 4'hF, '0, 1'b0);  // Ignored, LED alias in 4 bits
        add_step(OP_RD, 5'd31, '0, '0, 32'h0, 1'b0);
        add_step(OP_RD, `IO_REG_HW_CFG, '0, '0, `IO_HW_CONFIG, 1'b0);
    endtask

    initial begin
        int idle;
        int errs;
        axil_req  = '0;
        exp_rdata = '0;
        exp_model = 1'b0;
        rst_n     = 1'b1;
        build_table();
        wd_cycles = steps.size() * (STALL_MAX + DRAIN_CYCLES) + DRAIN_CYCLES + 32;
        repeat (16) @(posedge clk_cpu);
        rst_n <= 1'b0;
        @(posedge clk_cpu);
        foreach (steps[i]) begin
            get_rand(3, idle);
            repeat (idle) @(posedge clk_cpu);
            case (steps[i].op)
                OP_RD:   read_reg(steps[i].idx, steps[i].exp, steps[i].model);
                OP_WR:   write_reg(steps[i].idx, steps[i].data, steps[i].strb);
                default: wait_drain();
            endcase
        end
        repeat (4) @(posedge clk_cpu);
        if (pending != 0) begin
            $display("Bytes written to the transmit register never came out on tx_o");
            err_other++;
        end
        errs = err_rd + err_led + err_tx + err_bus + err_other
               + io_soc_top_i.io_soc_sva_i.fail_cnt;
        $display("Errors: read %0d, led %0d, uart %0d, bus %0d, assertion %0d, other %0d",
                 err_rd, err_led, err_tx, err_bus, io_soc_top_i.io_soc_sva_i.fail_cnt,
                 err_other);
        if (errs == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // Watchdog sized from the table length
    initial begin
        wait (wd_cycles > 0);
        repeat (wd_cycles) @(posedge clk_cpu);
        $display("Timeout: the run did not finish within %0d clock cycles", wd_cycles);
        $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+.
io_pkg.sv
io_axil_regs.sv
io_tx_fifo.sv
io_uart_tx.sv
io_soc_top.sv
io_soc_sva.sv
tb_io_checker.sv
tb_io_soc.sv
